//--- hw/spif_pkg.sv
/* Flash boot controller definitions */

package spif_pkg;

  // ========================================
  // Widths and types
  // ========================================
  localparam int WORD_W  = 18;                  // Processor cell width
  localparam int CODE_AW = 10;                  // Code RAM address bits
  localparam int DATA_AW = 10;                  // Data RAM address bits

  typedef logic [WORD_W-1:0] word_t;            // Data RAM word
  typedef logic [15:0]       insn_t;            // Code RAM word
  typedef logic [7:0]        byte_t;            // UART or flash byte
  typedef logic [15:0]       dest_t;            // Boot destination
  typedef logic [15:0]       count_t;           // Boot run length
  typedef logic [2:0]        ioaddr_t;          // I/O register select

  // ========================================
  // I/O register map
  // ========================================
  localparam ioaddr_t IO_CHAR        = 3'd0;    // Rx char / Tx byte
  localparam ioaddr_t IO_RXFULL      = 3'd1;    // Rx char pending
  localparam ioaddr_t IO_RATE_TXBUSY = 3'd2;    // Baud rate / Tx busy
  localparam ioaddr_t IO_FLASH       = 3'd3;    // Flash byte / restart
  localparam ioaddr_t IO_ISPFULL     = 3'd4;    // ISP pending / jam
  localparam ioaddr_t IO_BOOTING     = 3'd5;    // Boot in progress
  localparam ioaddr_t IO_ISPBYTE     = 3'd6;    // ISP byte

  // ========================================
  // Protocol constants
  // ========================================
  localparam byte_t FAST_READ = 8'h0B;          // SPI flash opcode
  localparam byte_t BASEBLOCK = 8'h00;          // First user sector

  localparam logic [5:0] ESC_PREFIX = 6'b000100; // 10h..13h on the UART
  localparam byte_t UNLOCK0 = 8'hA5;
  localparam byte_t UNLOCK1 = 8'h5A;

  localparam logic [15:0] UART_RATE_POR  = 16'd868; // Fclk / baud
  localparam logic [3:0]  FLASH_RATE_POR = 4'd7;    // SCLK divisor
  localparam logic [2:0]  FMT_BOOT       = 3'd2;    // Read with CS# held low

  // Boot sequencer state where nonzero means booting
  typedef enum logic [2:0] {
    BOOT_IDLE,
    HDR1,
    HDR2,
    HDR3,
    HDR4,
    HDR5,
    HDR6,
    INTERP
  } boot_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_ESC,                                     // After 10h
    RX_UNLOCK,                                  // After 12h
    RX_UNLOCK1                                  // After 12h A5h
  } rx_state_e;

endpackage

//--- hw/spram.sv
/* Single-port RAM */

module spram #(
  parameter int DEPTH_W = 10,                   // Address bits
  parameter int WIDTH   = 18                    // Word bits
) (
  input  logic               clk,
  input  logic [DEPTH_W-1:0] i_addr,
  input  logic [WIDTH-1:0]   i_din,
  output logic [WIDTH-1:0]   o_dout,
  input  logic               i_we,
  input  logic               i_re
);

  logic [WIDTH-1:0] mem [2**DEPTH_W];

  always_ff @(posedge clk) begin
    if (i_we) mem[i_addr] <= i_din;
    if (i_re) o_dout <= mem[i_addr];            // Old data on collision
  end

endmodule

//--- hw/uart_rx_filter.sv
/* UART receive filter */

module uart_rx_filter (
  input  logic            clk,
  input  logic            arstn,
  input  logic            i_u_full,             // UART holds a byte
  input  spif_pkg::byte_t i_u_din,
  output logic            o_u_rd,               // Byte consumed
  input  logic            i_take_char,
  input  logic            i_take_isp,
  input  logic            i_jam,                // Processor stuffs ISP byte
  input  spif_pkg::byte_t i_jam_byte,
  output spif_pkg::byte_t o_char,
  output spif_pkg::byte_t o_isp_byte,
  output logic            o_char_full,
  output logic            o_isp_full,
  output logic            o_isp_mode
);

  import spif_pkg::*;

  rx_state_e state;
  logic      rx_ok;                             // Fresh byte available
  logic      rx_ready;                          // Target register has room
  logic      dlv;                               // Byte delivered this cycle
  byte_t     dlv_byte;

  assign rx_ok    = i_u_full & ~o_u_rd;
  assign rx_ready = o_isp_mode ? ~o_isp_full & ~i_jam : ~o_char_full;

  always_comb begin
    dlv      = 1'b0;
    dlv_byte = i_u_din;
    if (rx_ok && rx_ready) begin
      if (state == RX_IDLE && i_u_din[7:2] != ESC_PREFIX) begin
        dlv = 1'b1;                             // Plain byte
      end
      if (state == RX_ESC) begin
        dlv      = 1'b1;
        dlv_byte = {ESC_PREFIX, i_u_din[1:0]};  // Unescaped 10h..13h
      end
    end
  end

  // ========================================
  // Escape and unlock FSM
  // ========================================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      state       <= RX_IDLE;
      o_u_rd      <= 1'b0;
      o_isp_mode  <= 1'b0;
      o_char_full <= 1'b0;
      o_isp_full  <= 1'b0;
    end else begin
      o_u_rd <= 1'b0;
      if (rx_ok) begin
        case (state)
          RX_IDLE: begin
            if (i_u_din[7:2] == ESC_PREFIX) begin
              o_u_rd <= 1'b1;                   // Prefix never delivered
              case (i_u_din[1:0])
                2'b00:   state <= RX_ESC;
                2'b10:   state <= RX_UNLOCK;
                default: state <= RX_IDLE;
              endcase
            end else if (rx_ready) begin
              o_u_rd <= 1'b1;
            end                                 // Else leave it in the UART
          end
          RX_ESC: begin
            if (rx_ready) begin
              o_u_rd <= 1'b1;
              state  <= RX_IDLE;
            end
          end
          RX_UNLOCK: begin
            o_u_rd     <= 1'b1;
            o_isp_mode <= 1'b0;                 // Broken sequence drops ISP
            state      <= (i_u_din == UNLOCK0) ? RX_UNLOCK1 : RX_IDLE;
          end
          default: begin
            o_u_rd <= 1'b1;
            if (i_u_din == UNLOCK1) begin
              o_isp_mode <= 1'b1;
            end
            state <= RX_IDLE;
          end
        endcase
      end
      if (i_take_char) o_char_full <= 1'b0;
      if (dlv && !o_isp_mode) o_char_full <= 1'b1;
      if (i_take_isp) o_isp_full <= 1'b0;
      if ((dlv && o_isp_mode) || i_jam) o_isp_full <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (dlv && !o_isp_mode) o_char <= dlv_byte;
    if (i_jam) begin
      o_isp_byte <= i_jam_byte;
    end else if (dlv && o_isp_mode) begin
      o_isp_byte <= dlv_byte;
    end
  end

endmodule

//--- hw/flash_boot.sv
/* Flash boot sequencer and interpreter */

module flash_boot (
  input  logic            clk,
  input  logic            arstn,
  input  logic            i_start,              // Restart interpretation
  input  logic            i_f_ready,            // Flash engine idle
  input  spif_pkg::byte_t i_f_din,              // Response of previous transfer
  output logic            o_f_wr,
  output spif_pkg::byte_t o_f_dout,
  output logic [2:0]      o_f_format,
  output logic [3:0]      o_f_rate,
  output logic            o_code_wr,
  output logic            o_data_wr,
  output spif_pkg::dest_t o_dest,
  output spif_pkg::word_t o_wdata,
  output logic            o_p_reset,
  output logic            o_booting
);

  import spif_pkg::*;

  boot_state_e state;
  logic [2:0]  mode;          // 00x cmd, 01x data, 10x addr, 11x count
  logic [1:0]  nbytes;        // Bytes per word minus one
  logic [1:0]  bytecnt;       // Bytes left in current word
  count_t      count;         // Words left minus one
  logic        skip;          // First response after restart is stale
  logic        f_ok;
  logic        interp;
  logic        take_data;
  byte_t       hdr_byte;

  assign f_ok      = i_f_ready & ~o_f_wr;
  assign interp    = f_ok & (state == INTERP) & ~skip;
  assign take_data = interp & (mode[2:1] == 2'b01);
  assign o_booting = (state != BOOT_IDLE);

  always_comb begin
    case (state)
      HDR1:    hdr_byte = FAST_READ;
      HDR2:    hdr_byte = BASEBLOCK;
      default: hdr_byte = 8'h00;                // Address bytes, then dummy
    endcase
  end

  // ========================================
  // Header sequencer and command decoder
  // ========================================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      state      <= HDR1;
      mode       <= 3'd0;
      nbytes     <= 2'd0;
      bytecnt    <= 2'd0;
      count      <= '0;
      skip       <= 1'b0;
      o_f_wr     <= 1'b0;
      o_f_dout   <= 8'h00;
      o_f_format <= 3'd0;
      o_f_rate   <= FLASH_RATE_POR;
      o_code_wr  <= 1'b0;
      o_data_wr  <= 1'b0;
      o_dest     <= '0;
      o_p_reset  <= 1'b1;
    end else begin
      o_f_wr    <= 1'b0;
      o_code_wr <= 1'b0;
      o_data_wr <= 1'b0;
      if (o_code_wr || o_data_wr) begin
        o_dest <= o_dest + 16'd1;               // Bump after each RAM write
      end
      if (f_ok && state != BOOT_IDLE) begin
        o_f_wr   <= 1'b1;
        o_f_dout <= hdr_byte;
        if (state == HDR1) o_f_format <= FMT_BOOT;
        if (state != INTERP) state <= boot_state_e'(state + 3'd1);
        if (state == INTERP) skip <= 1'b0;
      end
      if (interp) begin
        case (mode[2:1])
          2'b00: begin
            case (i_f_din[7:6])
              2'b11: begin
                if (i_f_din[5]) begin           // End of boot
                  o_f_wr     <= 1'b0;
                  o_f_format <= 3'd0;           // Raise CS#
                  o_p_reset  <= i_f_din[4];
                  state      <= BOOT_IDLE;
                end else begin
                  mode <= {1'b1, i_f_din[1:0]}; // Address or count load
                end
              end
              2'b10: o_f_rate <= i_f_din[3:0];
              default: begin                    // Data run
                mode    <= {2'b01, i_f_din[2]};
                nbytes  <= i_f_din[1:0];
                bytecnt <= i_f_din[1:0];
              end
            endcase
          end
          2'b01: begin
            if (bytecnt != 2'd0) begin
              bytecnt <= bytecnt - 2'd1;
            end else begin                      // Word complete
              bytecnt   <= nbytes;
              o_code_wr <= ~mode[0];
              o_data_wr <= mode[0];
              if (count != '0) count <= count - 16'd1;
              else mode <= 3'd0;
            end
          end
          2'b10: begin
            if (mode[0]) begin
              o_dest[15:8] <= i_f_din;
              mode[0]      <= 1'b0;
            end else begin
              o_dest[7:0] <= i_f_din;
              mode        <= 3'd0;
            end
          end
          default: begin
            if (mode[0]) begin
              count[15:8] <= i_f_din;
              mode[0]     <= 1'b0;
            end else begin
              count[7:0] <= i_f_din;
              mode       <= 3'd0;
            end
          end
        endcase
      end
      if (i_start) begin
        state <= INTERP;
        mode  <= 3'd0;
        skip  <= 1'b1;
      end
    end
  end

  // MSB first word assembly
  always_ff @(posedge clk) begin
    if (take_data) o_wdata <= {o_wdata[WORD_W-9:0], i_f_din};
  end

endmodule

//--- hw/host_port.sv
/* Processor I/O and RAM port */

module host_port (
  input  logic            clk,
  input  logic            arstn,
  input  logic            i_io_rd,
  input  logic            i_io_wr,
  input  logic            i_mem_rd,
  input  logic            i_mem_wr,
  input  logic [14:0]     i_mem_addr,           // Also the I/O select
  input  spif_pkg::word_t i_din,
  output spif_pkg::word_t o_mem_dout,
  output spif_pkg::word_t o_io_dout,
  input  logic [14:0]     i_code_addr,
  output spif_pkg::insn_t o_insn,
  output logic            o_hold,
  input  logic            i_u_ready,
  output logic            o_u_wr,
  output spif_pkg::byte_t o_u_dout,
  output logic [15:0]     o_u_rate,
  input  spif_pkg::byte_t i_f_din,
  input  spif_pkg::byte_t i_char,
  input  logic            i_char_full,
  input  spif_pkg::byte_t i_isp_byte,
  input  logic            i_isp_full,
  input  logic            i_booting,
  input  logic            i_code_wr,
  input  logic            i_data_wr,
  input  spif_pkg::dest_t i_dest,
  input  spif_pkg::word_t i_wdata,
  output logic            o_take_char,
  output logic            o_take_isp,
  output logic            o_jam,
  output spif_pkg::byte_t o_jam_byte,
  output logic            o_start
);

  import spif_pkg::*;

  ioaddr_t io_sel;
  logic    txbusy;
  logic    iobusy;                              // I/O wait state
  logic    rd_ok;
  logic    wr_ok;

  assign io_sel = i_mem_addr[2:0];
  assign txbusy = ~i_u_ready | o_u_wr;          // Strobe not yet seen by UART
  assign iobusy = i_io_wr & (((io_sel == IO_CHAR) & txbusy) |
                             ((io_sel == IO_ISPFULL) & i_isp_full));
  assign o_hold = i_code_wr | i_data_wr | iobusy;
  assign rd_ok  = i_io_rd & ~o_hold;
  assign wr_ok  = i_io_wr & ~o_hold;

  assign o_take_char = rd_ok & (io_sel == IO_CHAR);
  assign o_take_isp  = rd_ok & (io_sel == IO_ISPBYTE);
  assign o_jam       = wr_ok & (io_sel == IO_ISPFULL);
  assign o_jam_byte  = i_din[7:0];
  assign o_start     = wr_ok & (io_sel == IO_FLASH);

  always_comb begin
    case (io_sel)                               // Narrow values zero-extended
      IO_CHAR:        o_io_dout = word_t'(i_char);
      IO_RXFULL:      o_io_dout = word_t'(i_char_full);
      IO_RATE_TXBUSY: o_io_dout = word_t'(txbusy);
      IO_FLASH:       o_io_dout = word_t'(i_f_din);
      IO_ISPFULL:     o_io_dout = word_t'(i_isp_full);
      IO_BOOTING:     o_io_dout = word_t'(i_booting);
      IO_ISPBYTE:     o_io_dout = word_t'(i_isp_byte);
      default:        o_io_dout = '0;
    endcase
  end

  // ========================================
  // UART transmit and baud rate
  // ========================================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      o_u_wr   <= 1'b0;
      o_u_rate <= UART_RATE_POR;
    end else begin
      o_u_wr <= wr_ok & (io_sel == IO_CHAR);
      if (wr_ok && io_sel == IO_RATE_TXBUSY) o_u_rate <= i_din[15:0];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok && io_sel == IO_CHAR) o_u_dout <= i_din[7:0];
  end

  // ========================================
  // Boot writes take priority on the RAMs
  // ========================================
  spram #(
    .DEPTH_W (DATA_AW),
    .WIDTH   (WORD_W)
  ) data_ram (
    .clk    (clk),
    .i_addr (i_data_wr ? i_dest[DATA_AW-1:0] : i_mem_addr[DATA_AW-1:0]),
    .i_din  (i_data_wr ? i_wdata : i_din),
    .o_dout (o_mem_dout),
    .i_we   (i_data_wr | i_mem_wr),
    .i_re   (i_mem_rd & ~o_hold)
  );

  spram #(
    .DEPTH_W (CODE_AW),
    .WIDTH   (16)
  ) code_ram (
    .clk    (clk),
    .i_addr (i_code_wr ? i_dest[CODE_AW-1:0] : i_code_addr[CODE_AW-1:0]),
    .i_din  (i_wdata[15:0]),
    .o_dout (o_insn),
    .i_we   (i_code_wr),
    .i_re   (~o_hold)                           // Fetch stalls with the CPU
  );

endmodule

//--- hw/spif.sv
/* Serial flash boot controller */

module spif (
  input  logic             clk,
  input  logic             arstn,
  // Processor
  input  logic             i_io_rd,
  input  logic             i_io_wr,
  input  logic             i_mem_rd,
  input  logic             i_mem_wr,
  input  logic [14:0]      i_mem_addr,
  input  spif_pkg::word_t  i_din,
  output spif_pkg::word_t  o_mem_dout,
  output spif_pkg::word_t  o_io_dout,
  input  logic [14:0]      i_code_addr,
  output spif_pkg::insn_t  o_insn,
  output logic             o_p_hold,
  output logic             o_p_reset,
  output logic             o_booting,
  // UART
  input  logic             i_u_ready,
  output logic             o_u_wr,
  output spif_pkg::byte_t  o_u_dout,
  input  logic             i_u_full,
  output logic             o_u_rd,
  input  spif_pkg::byte_t  i_u_din,
  output logic [15:0]      o_u_rate,
  output logic             o_isp_mode,
  // SPI flash engine
  input  logic             i_f_ready,
  output logic             o_f_wr,
  output spif_pkg::byte_t  o_f_dout,
  output logic [2:0]       o_f_format,
  output logic [3:0]       o_f_rate,
  input  spif_pkg::byte_t  i_f_din
);

  import spif_pkg::*;

  byte_t char_byte, isp_byte, jam_byte;
  logic  char_full, isp_full;
  logic  take_char, take_isp, jam, start;
  logic  code_wr, data_wr;
  dest_t dest;
  word_t wdata;

  uart_rx_filter u_rx_filter (
    .clk         (clk),
    .arstn       (arstn),
    .i_u_full    (i_u_full),
    .i_u_din     (i_u_din),
    .o_u_rd      (o_u_rd),
    .i_take_char (take_char),
    .i_take_isp  (take_isp),
    .i_jam       (jam),
    .i_jam_byte  (jam_byte),
    .o_char      (char_byte),
    .o_isp_byte  (isp_byte),
    .o_char_full (char_full),
    .o_isp_full  (isp_full),
    .o_isp_mode  (o_isp_mode)
  );

  flash_boot u_flash_boot (
    .clk        (clk),
    .arstn      (arstn),
    .i_start    (start),
    .i_f_ready  (i_f_ready),
    .i_f_din    (i_f_din),
    .o_f_wr     (o_f_wr),
    .o_f_dout   (o_f_dout),
    .o_f_format (o_f_format),
    .o_f_rate   (o_f_rate),
    .o_code_wr  (code_wr),
    .o_data_wr  (data_wr),
    .o_dest     (dest),
    .o_wdata    (wdata),
    .o_p_reset  (o_p_reset),
    .o_booting  (o_booting)
  );

  host_port u_host_port (
    .clk         (clk),
    .arstn       (arstn),
    .i_io_rd     (i_io_rd),
    .i_io_wr     (i_io_wr),
    .i_mem_rd    (i_mem_rd),
    .i_mem_wr    (i_mem_wr),
    .i_mem_addr  (i_mem_addr),
    .i_din       (i_din),
    .o_mem_dout  (o_mem_dout),
    .o_io_dout   (o_io_dout),
    .i_code_addr (i_code_addr),
    .o_insn      (o_insn),
    .o_hold      (o_p_hold),
    .i_u_ready   (i_u_ready),
    .o_u_wr      (o_u_wr),
    .o_u_dout    (o_u_dout),
    .o_u_rate    (o_u_rate),
    .i_f_din     (i_f_din),
    .i_char      (char_byte),
    .i_char_full (char_full),
    .i_isp_byte  (isp_byte),
    .i_isp_full  (isp_full),
    .i_booting   (o_booting),
    .i_code_wr   (code_wr),
    .i_data_wr   (data_wr),
    .i_dest      (dest),
    .i_wdata     (wdata),
    .o_take_char (take_char),
    .o_take_isp  (take_isp),
    .o_jam       (jam),
    .o_jam_byte  (jam_byte),
    .o_start     (start)
  );

endmodule

//--- include/spif_tb_table.svh
/* Boot stream and test steps */

`ifndef SPIF_TB_TABLE_SVH
`define SPIF_TB_TABLE_SVH

// ========================================
// Flash side
// ========================================
localparam byte_t HDR_BYTES [6] = '{FAST_READ, BASEBLOCK, 8'h00, 8'h00, 8'h00, 8'h00};
localparam int    HDR_SKIP      = 5;            // Writes 1 to 5 return no data

// One response byte per flash transfer from write 6 on
localparam int    FLASH_LEN = 28;
localparam byte_t FLASH_STREAM [FLASH_LEN] = '{
  8'h85,                                        // SCLK divisor 5
  8'hC1, 8'h00, 8'h20,                          // Address 0020h in two bytes
  8'hC2, 8'h03,                                 // Count 3 for four words
  8'h01,                                        // Code RAM with 2 bytes per word
  8'h12, 8'h34, 8'h56, 8'h78,
  8'h9A, 8'hBC, 8'hDE, 8'hF0,
  8'hC0, 8'h40,                                 // Address low byte only
  8'hC2, 8'h01,                                 // Two words
  8'h06,                                        // Data RAM with 3 bytes per word
  8'h03, 8'hAB, 8'hCD,
  8'h01, 8'h23, 8'h45,
  8'hE0,                                        // End with r clear
  8'hF0                                         // End with r set after restart
};

// ========================================
// Steps as op, address or I/O select and data or expected value
// ========================================
localparam int    N_STEPS = 43;
localparam step_t STEPS [N_STEPS] = '{
  '{OP_BOOT,  15'd0,    18'd0},                 // p_reset from E0h
  '{OP_FRATE, 15'd0,    18'd5},
  '{OP_CODE,  15'h020,  18'h01234},
  '{OP_CODE,  15'h021,  18'h05678},
  '{OP_CODE,  15'h022,  18'h09ABC},
  '{OP_CODE,  15'h023,  18'h0DEF0},
  '{OP_DATA,  15'h040,  18'h3ABCD},             // 03h keeps only its low 2 bits
  '{OP_DATA,  15'h041,  18'h12345},
  '{OP_RD,    15'd5,    18'd0},                 // Booting low
  '{OP_UART,  15'd0,    18'h61},                // Plain byte
  '{OP_RD,    15'd1,    18'd1},
  '{OP_RD,    15'd0,    18'h61},
  '{OP_RD,    15'd1,    18'd0},
  '{OP_UART,  15'd0,    18'h10},                // Escape pair for 12h
  '{OP_UART,  15'd0,    18'h02},
  '{OP_RD,    15'd1,    18'd1},
  '{OP_RD,    15'd0,    18'h12},
  '{OP_RD,    15'd1,    18'd0},
  '{OP_UART,  15'd0,    18'h12},                // Unlock sequence
  '{OP_UART,  15'd0,    18'hA5},
  '{OP_UART,  15'd0,    18'h5A},
  '{OP_ISPM,  15'd0,    18'd1},
  '{OP_UART,  15'd0,    18'h3C},                // Goes to the ISP register
  '{OP_RD,    15'd1,    18'd0},
  '{OP_RD,    15'd4,    18'd1},
  '{OP_RD,    15'd6,    18'h3C},
  '{OP_RD,    15'd4,    18'd0},
  '{OP_WR,    15'd4,    18'h77},                // Jam into empty register
  '{OP_RD,    15'd4,    18'd1},
  '{OP_HOLD,  15'd4,    18'h88},                // Full register stalls the jam
  '{OP_RD,    15'd6,    18'h77},
  '{OP_WR,    15'd4,    18'h88},
  '{OP_RD,    15'd6,    18'h88},
  '{OP_URATE, 15'd0,    18'd868},
  '{OP_WR,    15'd2,    18'd434},
  '{OP_URATE, 15'd0,    18'd434},
  '{OP_WR,    15'd0,    18'h41},                // UART transmit
  '{OP_TX,    15'd0,    18'h41},
  '{OP_WR,    15'd3,    18'd0},                 // Restart interpreter
  '{OP_RD,    15'd5,    18'd1},
  '{OP_BOOT,  15'd0,    18'd1},                 // p_reset from F0h
  '{OP_RD,    15'd5,    18'd0},
  '{OP_RD,    15'd3,    18'hF0}                 // Last flash byte
};

`endif

//--- test/spif_tb.sv
/* Boot controller testbench */

module spif_tb;

  import spif_pkg::*;

  typedef enum logic [3:0] {
    OP_BOOT,                                    // Wait for booting low, check p_reset
    OP_FRATE,                                   // Flash SCLK divisor
    OP_CODE,                                    // Code RAM word
    OP_DATA,                                    // Data RAM word
    OP_UART,                                    // Present a received byte
    OP_RD,                                      // I/O read
    OP_WR,                                      // I/O write
    OP_HOLD,                                    // I/O write that must stall
    OP_TX,                                      // UART transmit strobe
    OP_URATE,                                   // UART divisor
    OP_ISPM                                     // ISP mode level
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [14:0] addr;
    word_t       data;
  } step_t;

  `include "spif_tb_table.svh"

  localparam int TIMEOUT_CYCLES = 8 * (HDR_SKIP + FLASH_LEN + 2) + 16 * N_STEPS + 100;

  logic        clk = 1'b0;
  logic        arstn = 1'b0;
  logic        i_io_rd = 1'b0;
  logic        i_io_wr = 1'b0;
  logic        i_mem_rd = 1'b0;
  logic        i_mem_wr = 1'b0;
  logic [14:0] i_mem_addr = '0;
  word_t       i_din = '0;
  logic [14:0] i_code_addr = '0;
  logic        i_u_ready = 1'b1;
  logic        i_u_full = 1'b0;
  byte_t       i_u_din = '0;
  logic        i_f_ready = 1'b0;
  byte_t       i_f_din = '0;
  word_t       o_mem_dout, o_io_dout;
  insn_t       o_insn;
  logic        o_p_hold, o_p_reset, o_booting;
  logic        o_u_wr, o_u_rd, o_isp_mode, o_f_wr;
  byte_t       o_u_dout, o_f_dout;
  logic [15:0] o_u_rate;
  logic [2:0]  o_f_format;
  logic [3:0]  o_f_rate;

  int          checks = 0;
  int          mismatches = 0;
  int          errors = 0;
  int          cycles = 0;
  integer      seed = 32'h7296a6f8;
  logic [31:0] rnd;
  int          f_count = 0;                     // Flash writes seen
  logic [2:0]  f_wait = '0;                     // Transfer cycles left
  byte_t       f_resp;
  byte_t       hdr_seen [6];
  logic [2:0]  hdr_fmt [6];

  always #4 clk = ~clk;

  spif UUT (
    .clk (clk), .arstn (arstn),
    .i_io_rd (i_io_rd), .i_io_wr (i_io_wr), .i_mem_rd (i_mem_rd), .i_mem_wr (i_mem_wr),
    .i_mem_addr (i_mem_addr), .i_din (i_din), .o_mem_dout (o_mem_dout),
    .o_io_dout (o_io_dout), .i_code_addr (i_code_addr), .o_insn (o_insn),
    .o_p_hold (o_p_hold), .o_p_reset (o_p_reset), .o_booting (o_booting),
    .i_u_ready (i_u_ready), .o_u_wr (o_u_wr), .o_u_dout (o_u_dout), .i_u_full (i_u_full),
    .o_u_rd (o_u_rd), .i_u_din (i_u_din), .o_u_rate (o_u_rate), .o_isp_mode (o_isp_mode),
    .i_f_ready (i_f_ready), .o_f_wr (o_f_wr), .o_f_dout (o_f_dout),
    .o_f_format (o_f_format), .o_f_rate (o_f_rate), .i_f_din (i_f_din)
  );

  function automatic byte_t flash_response(input int idx);
    if (idx < HDR_SKIP || idx - HDR_SKIP >= FLASH_LEN) return 8'hFF; // Also decodes as end
    return FLASH_STREAM[idx - HDR_SKIP];
  endfunction

  // ========================================
  // SPI flash engine model
  // ========================================
  always @(posedge clk) begin
    if (!arstn) begin
      i_f_ready <= 1'b1;
      f_wait    <= 3'd0;
      f_count   <= 0;
    end else if (f_wait != 3'd0) begin
      f_wait <= f_wait - 3'd1;
      if (f_wait == 3'd1) begin                 // Transfer done
        i_f_din   <= f_resp;
        i_f_ready <= 1'b1;
      end
    end else if (o_f_wr) begin
      if (f_count < 6) begin
        hdr_seen[f_count] <= o_f_dout;
        hdr_fmt[f_count]  <= o_f_format;
      end
      rnd        = $random(seed);
      f_resp    <= flash_response(f_count);
      f_count   <= f_count + 1;
      f_wait    <= 3'd1 + {1'b0, rnd[1:0]};    // 1 to 4 cycles
      i_f_ready <= 1'b0;
    end
  end

  task automatic expect_value(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      mismatches++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic io_read(input logic [14:0] addr, input word_t exp);
    @(posedge clk);
    i_io_rd    <= 1'b1;
    i_mem_addr <= addr;
    @(posedge clk);
    while (o_p_hold) @(posedge clk);
    expect_value($sformatf("o_io_dout (I/O %0d)", addr), o_io_dout, exp);
    i_io_rd <= 1'b0;
  endtask

  task automatic io_write(input logic [14:0] addr, input word_t data);
    @(posedge clk);
    i_io_wr    <= 1'b1;
    i_mem_addr <= addr;
    i_din      <= data;
    @(posedge clk);
    while (o_p_hold) @(posedge clk);           // Accepted at this edge
    i_io_wr <= 1'b0;
  endtask

  // Write stays stalled, then the CPU side gives up
  task automatic held_write(input logic [14:0] addr, input word_t data);
    @(posedge clk);
    i_io_wr    <= 1'b1;
    i_mem_addr <= addr;
    i_din      <= data;
    repeat (4) begin
      @(posedge clk);
      expect_value("o_p_hold", word_t'(o_p_hold), 18'd1);
    end
    i_io_wr <= 1'b0;
  endtask

  task automatic uart_send(input byte_t b);
    @(posedge clk);
    i_u_full <= 1'b1;
    i_u_din  <= b;
    @(posedge clk);
    while (!o_u_rd) @(posedge clk);
    i_u_full <= 1'b0;
  endtask

  task automatic code_read(input logic [14:0] addr, input word_t exp);
    @(posedge clk);
    i_code_addr <= addr;
    @(posedge clk);                             // RAM samples the address
    @(posedge clk);
    expect_value($sformatf("o_insn (%h)", addr), word_t'(o_insn), exp);
  endtask

  task automatic data_read(input logic [14:0] addr, input word_t exp);
    @(posedge clk);
    i_mem_rd   <= 1'b1;
    i_mem_addr <= addr;
    @(posedge clk);
    i_mem_rd <= 1'b0;
    @(posedge clk);
    expect_value($sformatf("o_mem_dout (%h)", addr), o_mem_dout, exp);
  endtask

  task automatic wait_boot(input word_t exp_reset);
    @(posedge clk);
    while (o_booting) @(posedge clk);
    expect_value("o_p_reset", word_t'(o_p_reset), exp_reset);
  endtask

  task automatic run_step(input step_t s);
    case (s.op)
      OP_BOOT: wait_boot(s.data);
      OP_CODE: code_read(s.addr, s.data);
      OP_DATA: data_read(s.addr, s.data);
      OP_UART: uart_send(s.data[7:0]);
      OP_RD:   io_read(s.addr, s.data);
      OP_WR:   io_write(s.addr, s.data);
      OP_HOLD: held_write(s.addr, s.data);
      OP_TX: begin
        @(posedge clk);
        expect_value("o_u_wr", word_t'(o_u_wr), 18'd1);
        expect_value("o_u_dout", word_t'(o_u_dout), s.data);
      end
      OP_FRATE: begin
        @(posedge clk);
        expect_value("o_f_rate", word_t'(o_f_rate), s.data);
      end
      OP_URATE: begin
        @(posedge clk);
        expect_value("o_u_rate", word_t'(o_u_rate), s.data);
      end
      default: begin
        @(posedge clk);
        expect_value("o_isp_mode", word_t'(o_isp_mode), s.data);
      end
    endcase
  endtask

  // Watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: steps did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, errors);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    repeat (3) @(posedge clk);
    arstn <= 1'b1;
    for (int i = 0; i < N_STEPS; i++) begin
      run_step(STEPS[i]);
    end
    assert (f_count >= 6) else begin
      errors++;
      $display("Flash engine saw only %0d writes, the read header needs 6", f_count);
    end
    for (int i = 0; i < 6; i++) begin
      expect_value($sformatf("o_f_dout (header %0d)", i), word_t'(hdr_seen[i]),
                   word_t'(HDR_BYTES[i]));
      expect_value($sformatf("o_f_format (header %0d)", i), word_t'(hdr_fmt[i]),
                   word_t'(FMT_BOOT));
    end
    $display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, errors);
    if (mismatches == 0 && errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- spif.f
+incdir+include
hw/spif_pkg.sv
hw/spram.sv
hw/uart_rx_filter.sv
hw/flash_boot.sv
hw/host_port.sv
hw/spif.sv
test/spif_tb.sv

//--- Makefile
# Verilator build and run of the flash boot controller testbench

VERILATOR ?= verilator
TOP       ?= spif_tb
FILELIST  ?= spif.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

SRCS := $(shell grep -v '^+' $(FILELIST)) include/spif_tb_table.svh

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run, search the log for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "TEST PASSED"; \
	else \
	  echo "TEST FAILED, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
